/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module tb_rv_ctrl \
	  -f rv_ctrl_top.f -Mdir obj_dir -o sim_rv_ctrl
	-./obj_dir/sim_rv_ctrl > sim.log 2>&1
	@cat sim.log
	@if grep -q "Verification failed" sim.log; then \
	  echo "TEST FAILED"; exit 1; \
	elif ! grep -q "Verification passed" sim.log; then \
	  echo "TEST FAILED: simulation ended without a result"; exit 1; \
	else \
	  echo "TEST PASSED"; \
	fi

clean:
	rm -rf obj_dir sim.log

/* hdl/ctrl_gen.sv */
module ctrl_gen #(
  parameter int XLEN = 64 // 32 or 64
) (
  input  logic                       clk,
  input  logic                       rst_n,
  // Classified stream in
  input  logic                       cls_valid,
  input  rv_ctrl_pkg::inst_class_t   cls,
  output logic                       cls_ready,
  // Control words out
  output logic                       out_valid,
  output rv_ctrl_pkg::ctrl_word_t    out_ctrl,
  input  logic                       out_ready
);

  import rv_ctrl_pkg::*;

  // Word opcodes exist only on RV64
  localparam bit WORD_OK = (XLEN == 64);

  ctrl_word_t ctrl_next;
  logic       word_form;   // OP_IMM_32 or OP_OP_32
  logic       accept;

  // ALU op from funct3 and funct7[5]
  function automatic alu_op_e alu_sel(
    input logic [2:0] f3,
    input logic       f7_b5,
    input logic       is_reg     // SUB only exists in register form
  );
    alu_op_e op;
    case (f3)
      3'b000: begin
        if (is_reg && f7_b5) begin
          op = ALU_SUB;
        end else begin
          op = ALU_ADD;          // ADDI ignores bit 30
        end
      end
      3'b001: op = ALU_SLL;
      3'b010: op = ALU_SLT;
      3'b011: op = ALU_SLTU;
      3'b100: op = ALU_XOR;
      3'b101: begin
        if (f7_b5) begin
          op = ALU_SRA;          // Also SRAI
        end else begin
          op = ALU_SRL;
        end
      end
      3'b110: op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign word_form = (cls.opcode == OP_IMM_32) || (cls.opcode == OP_OP_32);

  always_comb begin
    ctrl_next = '0; // Also the ECALL/EBREAK/FENCE word

    case (cls.opcode)
      OP_LUI, OP_AUIPC: begin
        ctrl_next.reg_write = 1'b1;
        ctrl_next.alu_src   = 1'b1;
        ctrl_next.alu_op    = ALU_ADD;   // 0 + imm or pc + imm
        ctrl_next.wb_sel    = WB_ALU;
        ctrl_next.imm_sel   = IMM_U;
      end

      OP_JAL: begin
        ctrl_next.reg_write = 1'b1;
        ctrl_next.jump      = 1'b1;
        ctrl_next.wb_sel    = WB_PC4;
        ctrl_next.imm_sel   = IMM_J;
      end

      OP_JALR: begin
        ctrl_next.reg_write = 1'b1;
        ctrl_next.jump      = 1'b1;
        ctrl_next.alu_src   = 1'b1;
        ctrl_next.alu_op    = ALU_ADD;   // Target rs1 + imm
        ctrl_next.wb_sel    = WB_PC4;
        ctrl_next.imm_sel   = IMM_I;
      end

      OP_BRANCH: begin
        ctrl_next.branch  = 1'b1;
        ctrl_next.alu_op  = ALU_SUB;     // Compare
        ctrl_next.imm_sel = IMM_B;
      end

      OP_LOAD: begin
        ctrl_next.reg_write = 1'b1;
        ctrl_next.mem_read  = 1'b1;
        ctrl_next.alu_src   = 1'b1;
        ctrl_next.alu_op    = ALU_ADD;   // Address
        ctrl_next.wb_sel    = WB_MEM;
        ctrl_next.imm_sel   = IMM_I;
      end

      OP_STORE: begin
        ctrl_next.mem_write = 1'b1;
        ctrl_next.alu_src   = 1'b1;
        ctrl_next.alu_op    = ALU_ADD;
        ctrl_next.imm_sel   = IMM_S;
      end

      OP_IMM, OP_IMM_32: begin
        if (word_form && !WORD_OK) begin
          ctrl_next.illegal = 1'b1;      // ADDIW etc. on RV32
        end else begin
          ctrl_next.reg_write = 1'b1;
          ctrl_next.alu_src   = 1'b1;
          ctrl_next.alu_op    = alu_sel(cls.funct3, cls.funct7[5], 1'b0);
          ctrl_next.wb_sel    = WB_ALU;
          ctrl_next.imm_sel   = IMM_I;
        end
      end

      OP_OP, OP_OP_32: begin
        if (word_form && !WORD_OK) begin
          ctrl_next.illegal = 1'b1;
        end else if (cls.is_mul_div) begin
          // MUL/DIV/REM and their W forms
          ctrl_next.reg_write  = 1'b1;
          ctrl_next.mul_div_en = 1'b1;
          ctrl_next.mul_div_op = cls.mul_div_op;
          ctrl_next.word_op    = cls.is_word_op;
          ctrl_next.wb_sel     = WB_MDU;
        end else begin
          ctrl_next.reg_write = 1'b1;
          ctrl_next.alu_op    = alu_sel(cls.funct3, cls.funct7[5], 1'b1);
          ctrl_next.wb_sel    = WB_ALU;
        end
      end

      OP_FENCE: begin
        ctrl_next.alu_op = ALU_ADD; // Treated as a no-op
      end

      OP_SYSTEM: begin
        case (cls.sys_kind)
          SYS_CSR: begin
            ctrl_next.reg_write = 1'b1;  // Old CSR value to rd
            ctrl_next.csr_we    = 1'b1;  // Core suppresses the write when needed
            ctrl_next.csr_src   = cls.funct3[2];
            ctrl_next.wb_sel    = WB_CSR;
          end
          SYS_ECALL, SYS_EBREAK: begin
            ctrl_next.jump = 1'b0;       // Trap is raised by the core
          end
          SYS_MRET: ctrl_next.jump = 1'b1;
          default:  ctrl_next.illegal = 1'b1;
        endcase
      end

      default: ctrl_next.illegal = 1'b1; // Unknown opcode
    endcase
  end

  // Output stage handshake
  assign cls_ready = !out_valid || out_ready;
  assign accept    = cls_valid && cls_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (cls_ready) begin
      out_valid <= cls_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_ctrl <= ctrl_next;
    end
  end

endmodule

/* hdl/inst_classify.sv */
module inst_classify (
  input  logic                              clk,
  input  logic                              rst_n,
  // Instruction stream in
  input  logic                              in_valid,
  input  logic [rv_ctrl_pkg::INSTR_W-1:0]   in_instr,
  output logic                              in_ready,
  // Classified stream out
  output logic                              cls_valid,
  output rv_ctrl_pkg::inst_class_t          cls,
  input  logic                              cls_ready
);

  import rv_ctrl_pkg::*;

  logic [6:0]  opc_raw;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [11:0] imm12;    // I-type immediate selecting ECALL/EBREAK/MRET
  logic        is_op;    // OP or OP_OP_32
  logic        is_op32;
  sys_kind_e   sys_kind;
  inst_class_t cls_next;
  logic        accept;

  // Field slicing
  assign opc_raw = in_instr[6:0];
  assign funct3  = in_instr[14:12];
  assign funct7  = in_instr[31:25];
  assign imm12   = in_instr[31:20];

  assign is_op32 = (opc_raw == OP_OP_32);
  assign is_op   = (opc_raw == OP_OP) || is_op32;

  // SYSTEM sub-kind
  always_comb begin
    sys_kind = SYS_NONE;
    if (opc_raw == OP_SYSTEM) begin
      if (funct3 != 3'b000) begin
        sys_kind = SYS_CSR; // CSRRW..CSRRCI
      end else begin
        case (imm12)
          12'h000: sys_kind = SYS_ECALL;
          12'h001: sys_kind = SYS_EBREAK;
          12'h302: sys_kind = SYS_MRET;
          default: sys_kind = SYS_BAD;   // WFI, SRET and friends not supported
        endcase
      end
    end
  end

  always_comb begin
    cls_next            = '0;
    cls_next.opcode     = opcode_e'(opc_raw); // Unknown values pass through
    cls_next.funct3     = funct3;
    cls_next.funct7     = funct7;
    cls_next.is_mul_div = is_op && (funct7 == 7'b0000001);
    cls_next.mul_div_op = {1'b0, funct3};
    cls_next.is_word_op = is_op32;
    cls_next.sys_kind   = sys_kind;
  end

  // Free slot or one draining this cycle
  assign in_ready = !cls_valid || cls_ready;
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cls_valid <= 1'b0;
    end else if (in_ready) begin
      cls_valid <= in_valid; // Held while stalled
    end
  end

  // Payload register
  always_ff @(posedge clk) begin
    if (accept) begin
      cls <= cls_next;
    end
  end

endmodule

/* hdl/rv_ctrl_pkg.sv */
package rv_ctrl_pkg;

  // Instruction word width
  localparam int INSTR_W = 32;

  // Major opcodes handled by the decoder
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_OP     = 7'b0110011,
    OP_FENCE  = 7'b0001111,
    OP_SYSTEM = 7'b1110011,
    OP_IMM_32 = 7'b0011011, // ADDIW, SLLIW, SRLIW, SRAIW
    OP_OP_32  = 7'b0111011  // ADDW..SRAW and RV64M word ops
  } opcode_e;

  // ALU operation in datapath order
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  // Write-back source
  typedef enum logic [2:0] {
    WB_ALU = 3'd0,
    WB_MEM = 3'd1,
    WB_PC4 = 3'd2, // Link address
    WB_CSR = 3'd3,
    WB_MDU = 3'd4  // Multiply/divide unit
  } wb_sel_e;

  // Immediate format
  typedef enum logic [2:0] {
    IMM_I = 3'd0,
    IMM_S = 3'd1,
    IMM_B = 3'd2,
    IMM_U = 3'd3,
    IMM_J = 3'd4
  } imm_sel_e;

  // SYSTEM opcode sub-kinds
  typedef enum logic [2:0] {
    SYS_NONE   = 3'd0, // Not a SYSTEM instruction
    SYS_CSR    = 3'd1,
    SYS_ECALL  = 3'd2,
    SYS_EBREAK = 3'd3,
    SYS_MRET   = 3'd4,
    SYS_BAD    = 3'd5  // Malformed SYSTEM encoding
  } sys_kind_e;

  // Classified instruction from stage 1
  typedef struct packed {
    opcode_e     opcode;     // May hold an unknown value
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic        is_mul_div; // M extension
    logic [3:0]  mul_div_op; // funct3 zero-extended
    logic        is_word_op; // OP_OP_32 form
    sys_kind_e   sys_kind;
  } inst_class_t;

  // Control word from stage 2 to the core
  typedef struct packed {
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    logic     branch;
    logic     jump;
    alu_op_e  alu_op;
    logic     alu_src;    // 1 selects immediate
    wb_sel_e  wb_sel;
    imm_sel_e imm_sel;
    logic     csr_we;
    logic     csr_src;    // 1 selects uimm
    logic     mul_div_en;
    logic [3:0] mul_div_op;
    logic     word_op;
    logic     illegal;
  } ctrl_word_t;

endpackage

/* hdl/rv_ctrl_top.sv */
module rv_ctrl_top #(
  parameter int XLEN = 64 // 32 or 64
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              in_valid,
  input  logic [rv_ctrl_pkg::INSTR_W-1:0]   in_instr,
  output logic                              in_ready,
  output logic                              out_valid,
  output rv_ctrl_pkg::ctrl_word_t           out_ctrl,
  input  logic                              out_ready
);

  import rv_ctrl_pkg::*;

  // Stage 1 to stage 2
  logic        cls_valid;
  logic        cls_ready;
  inst_class_t cls;

  // Field split and sub-kind decode
  inst_classify u_inst_classify (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_instr  (in_instr),
    .in_ready  (in_ready),
    .cls_valid (cls_valid),
    .cls       (cls),
    .cls_ready (cls_ready)
  );

  // Control word generation
  ctrl_gen #(
    .XLEN (XLEN)
  ) u_ctrl_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .cls_valid (cls_valid),
    .cls       (cls),
    .cls_ready (cls_ready),
    .out_valid (out_valid),
    .out_ctrl  (out_ctrl),
    .out_ready (out_ready)
  );

endmodule

/* rv_ctrl_top.f */
hdl/rv_ctrl_pkg.sv
hdl/inst_classify.sv
hdl/ctrl_gen.sv
hdl/rv_ctrl_top.sv
verif/rv_ctrl_checker.sv
verif/tb_rv_ctrl.sv

/* verif/rv_ctrl_checker.sv */
module rv_ctrl_checker (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    out_valid,
  input  logic                    out_ready,
  input  rv_ctrl_pkg::ctrl_word_t out_ctrl
);

  // Output stage stays empty while reset is held
  a_reset_idle: assert property (@(posedge clk) !rst_n |-> !out_valid)
    else $error("out_valid high while rst_n is low");

  // Stalled output keeps its word and its valid
  a_hold_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_ctrl)
  ) else $error("out_ctrl or out_valid changed while stalled");

  // Illegal word never writes state
  a_illegal_quiet: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid && out_ctrl.illegal |-> !out_ctrl.reg_write && !out_ctrl.mem_write
  ) else $error("illegal control word with reg_write or mem_write set");

endmodule

// Attach to every decoder top
bind rv_ctrl_top rv_ctrl_checker u_rv_ctrl_checker (
  .clk       (clk),
  .rst_n     (rst_n),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_ctrl  (out_ctrl)
);

/* verif/rv_ctrl_vectors.txt */
// Columns: instruction, expected control word (25 bits, zero-extended)
// Word MSB first: rw mr mw br j alu[4] src wb[3] imm[3] csr_we csr_src md_en md_op[4] wop ill
123450B7 01008600 // LUI
00001117 01008600 // AUIPC
000000EF 01102800 // JAL
000100E7 0110A000 // JALR
00208063 00210400 // BEQ
00209063 00210400 // BNE
00012083 01809000 // LW
00112023 00408200 // SW
00108093 01008000 // ADDI
40008093 01008000 // ADDI with bit 30 set stays ADD
0020A093 01038000 // SLTI
4030D093 01078000 // SRAI
0030D093 01068000 // SRLI
0FF0F093 01098000 // ANDI
002081B3 01000000 // ADD
402081B3 01010000 // SUB
4020D1B3 01070000 // SRA
0020C1B3 01050000 // XOR
0020B1B3 01040000 // SLTU
0020E1B3 01080000 // OR
002091B3 01020000 // SLL
0000000F 00000000 // FENCE
022081B3 01004040 // MUL
0220C1B3 01004050 // DIV
0220F1B3 0100405C // REMU
022081BB 01004042 // MULW
0220D1BB 01004056 // DIVUW
002081BB 01000000 // ADDW
402081BB 01010000 // SUBW
0010809B 01008000 // ADDIW
4030D09B 01078000 // SRAIW
30011073 01003100 // CSRRW
3002E0F3 01003180 // CSRRSI
00000073 00000000 // ECALL
00100073 00000000 // EBREAK
30200073 00100000 // MRET
10500073 00000001 // WFI, unsupported
0000007F 00000001 // Unknown opcode
00000000 00000001 // All-zero word
00200073 00000001 // SYSTEM with bad imm12
0000202F 00000001 // AMO, not supported

/* verif/tb_rv_ctrl.sv */
module tb_rv_ctrl;

  import rv_ctrl_pkg::*;

  localparam int XLEN      = 64;
  localparam int NUM_VEC   = 41;                 // Lines in the vectors file
  localparam int CW        = $bits(ctrl_word_t);
  localparam int STALL_MAX = 200;                // Cycles with no transfer at all
  localparam int SETTLE    = 25;                 // Falling edge to sample point

  logic               clk;
  logic               rst_n;
  logic               in_valid;
  logic [INSTR_W-1:0] in_instr;
  logic               in_ready;
  logic               out_valid;
  ctrl_word_t         out_ctrl;
  logic               out_ready;

  logic [31:0] vec_mem [0:2*NUM_VEC-1]; // Instruction then control word per vector
  logic [31:0] rng;                     // Back-pressure state
  int          n_in;                    // Instructions accepted
  int          n_out;                   // Control words checked
  int          stall;
  ctrl_word_t  exp_ctrl;

  rv_ctrl_top #(
    .XLEN (XLEN)
  ) u_rv_ctrl_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_instr  (in_instr),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ctrl  (out_ctrl),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // 32-bit xorshift step
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  initial begin
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_instr  = '0;
    out_ready = 1'b0;
    rng       = 32'd87;
    n_in      = 0;
    n_out     = 0;
    stall     = 0;
    $readmemh("verif/rv_ctrl_vectors.txt", vec_mem);

    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Pipeline stays empty with nothing offered
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      assert (!out_valid && in_ready) else
        abort_run($sformatf("Mismatch at time %0t: pipeline not idle after reset", $time));
    end

    while (n_out < NUM_VEC) begin
      @(negedge clk);
      rng       = xorshift32(rng);
      out_ready = rng[0];             // Random sink stalls
      in_valid  = (n_in < NUM_VEC);
      if (n_in < NUM_VEC) begin
        in_instr = vec_mem[2*n_in];   // Held until accepted
      end
      #(SETTLE);                      // Handshake as seen by the next rising edge
      stall = stall + 1;
      if (out_valid && out_ready) begin
        assert (n_out < n_in) else
          abort_run($sformatf("Mismatch at time %0t: output with no instruction accepted",
                              $time));
        exp_ctrl = ctrl_word_t'(vec_mem[2*n_out+1][CW-1:0]);
        assert (out_ctrl === exp_ctrl) else
          abort_run($sformatf("Mismatch at time %0t: vector %0d instr %08h got %07h exp %07h",
                              $time, n_out, vec_mem[2*n_out], out_ctrl, exp_ctrl));
        n_out = n_out + 1;
        stall = 0;
      end
      if (in_valid && in_ready) begin
        n_in  = n_in + 1;
        stall = 0;
      end
      assert (stall <= STALL_MAX) else
        abort_run($sformatf("Timeout: no transfer for %0d cycles, %0d in and %0d out",
                            STALL_MAX, n_in, n_out));
      @(posedge clk);
    end

    // No extra words may follow the last vector
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      in_valid  = 1'b0;
      out_ready = 1'b1;
      #(SETTLE);
      assert (!out_valid) else
        abort_run($sformatf("Mismatch at time %0t: extra output after last vector", $time));
    end

    $display("Verification passed");
    $finish;
  end

endmodule
